/* design/mips_op_pkg.sv */
package mips_op_pkg;

	parameter int XLEN_DEF = 32;	// Integer datapath width

	// Codes follow the original ALU control word where one exists
	typedef enum logic [4:0] {
		OP_AND   = 5'b00000,
		OP_OR    = 5'b00001,
		OP_XOR   = 5'b00010,
		OP_ADDU  = 5'b00011,
		OP_SUBU  = 5'b00100,
		OP_SLTU  = 5'b00101,
		OP_SLT   = 5'b00110,
		OP_MULTU = 5'b00111,
		OP_MULT  = 5'b01000,
		OP_SLL   = 5'b01001,	// Shift amount in low bits of b
		OP_SRA   = 5'b01011,
		OP_SRL   = 5'b01100,
		OP_DIV   = 5'b01111,
		OP_DIVU  = 5'b10000,
		OP_MFHI  = 5'b10001,
		OP_MFLO  = 5'b10010,
		OP_BLTZ  = 5'b10011,	// Branch tests give zero when taken
		OP_BGTZ  = 5'b10100,
		OP_BEQZ  = 5'b10101,
		OP_BNEZ  = 5'b10110,
		OP_LUI   = 5'b10111,
		OP_PASSA = 5'b11000	// Register jump target
	} alu_op_e;

	function automatic logic is_muldiv(input alu_op_e op);
		return op inside {OP_MULT, OP_MULTU, OP_DIV, OP_DIVU, OP_MFHI, OP_MFLO};
	endfunction

endpackage

/* design/mips_wb_pkg.sv */
package mips_wb_pkg;

	parameter int RD_W = 5;	// Destination register number

	// Owner of a writeback slot
	typedef enum logic {
		SRC_ALU = 1'b0,
		SRC_MD  = 1'b1
	} wb_src_e;

	// Iterative divider sequencing
	typedef enum logic [1:0] {
		DIV_IDLE = 2'd0,	// Free for a new operation
		DIV_RUN  = 2'd1,	// One quotient bit per cycle
		DIV_FIX  = 2'd2	// Sign and zero-divisor correction
	} div_state_e;

endpackage

/* design/alu_unit.sv */
`timescale 1ns/1ps

module alu_unit #(
	parameter int XLEN = 32
) (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         issue_valid,
	input  mips_op_pkg::alu_op_e         issue_op,
	input  logic [XLEN-1:0]              issue_a,
	input  logic [XLEN-1:0]              issue_b,
	input  logic [mips_wb_pkg::RD_W-1:0] issue_rd,
	input  logic                         alu_gnt,
	output logic                         alu_ready,
	output logic                         alu_req,
	output logic [mips_wb_pkg::RD_W-1:0] alu_rd,
	output logic [XLEN-1:0]              alu_data,
	output logic                         alu_zero
);

	localparam int SH_W = $clog2(XLEN);

	logic [XLEN-1:0] y;
	logic [SH_W-1:0] shamt;
	logic            take;

	assign shamt = issue_b[SH_W-1:0];	// Merged immediate and variable shifts

	always_comb begin
		case (issue_op)
			mips_op_pkg::OP_AND:   y = issue_a & issue_b;
			mips_op_pkg::OP_OR:    y = issue_a | issue_b;
			mips_op_pkg::OP_XOR:   y = issue_a ^ issue_b;
			mips_op_pkg::OP_ADDU:  y = issue_a + issue_b;
			mips_op_pkg::OP_SUBU:  y = issue_a - issue_b;
			mips_op_pkg::OP_SLTU:  y = {{(XLEN-1){1'b0}}, issue_a < issue_b};
			mips_op_pkg::OP_SLT:   y = {{(XLEN-1){1'b0}}, $signed(issue_a) < $signed(issue_b)};
			mips_op_pkg::OP_SLL:   y = issue_a << shamt;
			mips_op_pkg::OP_SRL:   y = issue_a >> shamt;
			mips_op_pkg::OP_SRA:   y = $signed(issue_a) >>> shamt;
			mips_op_pkg::OP_LUI:   y = issue_b << (XLEN / 2);
			mips_op_pkg::OP_BLTZ: begin
				y = issue_a[XLEN-1] ? '0 : XLEN'(1);	// Negative
			end
			mips_op_pkg::OP_BGTZ: begin
				y = (!issue_a[XLEN-1] && issue_a != '0) ? '0 : XLEN'(1);
			end
			mips_op_pkg::OP_BEQZ:  y = (issue_a == '0) ? '0 : XLEN'(1);
			mips_op_pkg::OP_BNEZ:  y = (issue_a != '0) ? '0 : XLEN'(1);
			mips_op_pkg::OP_PASSA: y = issue_a;
			default:               y = '0;	// Multiply/divide class, never taken here
		endcase
	end

	// A grant frees the slot for an issue on the same edge
	assign alu_ready = !alu_req || alu_gnt;
	assign take      = issue_valid && alu_ready && !mips_op_pkg::is_muldiv(issue_op);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			alu_req <= 1'b0;
		end else if (take) begin
			alu_req <= 1'b1;
		end else if (alu_gnt) begin
			alu_req <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			alu_rd   <= issue_rd;
			alu_data <= y;
			alu_zero <= (y == '0);	// Branch taken flag
		end
	end

endmodule

/* design/muldiv_unit.sv */
`timescale 1ns/1ps

module muldiv_unit #(
	parameter int XLEN = 32
) (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         issue_valid,
	input  mips_op_pkg::alu_op_e         issue_op,
	input  logic [XLEN-1:0]              issue_a,
	input  logic [XLEN-1:0]              issue_b,
	input  logic [mips_wb_pkg::RD_W-1:0] issue_rd,
	input  logic                         md_gnt,
	output logic                         md_ready,
	output logic                         md_busy,
	output logic                         md_req,
	output logic [mips_wb_pkg::RD_W-1:0] md_rd,
	output logic [XLEN-1:0]              md_data,
	output logic                         md_zero
);

	localparam int CNT_W = $clog2(XLEN + 1);

	mips_wb_pkg::div_state_e div_state;
	logic [XLEN-1:0]   hi;
	logic [XLEN-1:0]   lo;
	logic [CNT_W-1:0]  cnt;
	logic [XLEN-1:0]   quo;	// Dividend shifts out as quotient shifts in
	logic [XLEN-1:0]   rem;
	logic [XLEN-1:0]   dvs;
	logic [XLEN-1:0]   dvd;
	logic              neg_q;
	logic              neg_r;
	logic              dzero;
	logic              take;
	logic              sgn;
	logic [2*XLEN-1:0] prod;
	logic [XLEN:0]     shifted;
	logic [XLEN:0]     diff;
	logic [XLEN-1:0]   mag_a;
	logic [XLEN-1:0]   mag_b;
	logic [XLEN-1:0]   mf_val;

	assign md_busy  = (div_state != mips_wb_pkg::DIV_IDLE);
	assign md_ready = !md_busy && (!md_req || md_gnt);
	assign take     = issue_valid && md_ready && mips_op_pkg::is_muldiv(issue_op);
	assign sgn      = (issue_op == mips_op_pkg::OP_MULT) || (issue_op == mips_op_pkg::OP_DIV);

	always_comb begin
		if (sgn) begin
			prod = $signed(issue_a) * $signed(issue_b);
		end else begin
			prod = issue_a * issue_b;
		end
	end

	assign mag_a   = (sgn && issue_a[XLEN-1]) ? -issue_a : issue_a;
	assign mag_b   = (sgn && issue_b[XLEN-1]) ? -issue_b : issue_b;
	assign shifted = {rem, quo[XLEN-1]};
	assign diff    = shifted - {1'b0, dvs};	// Trial subtract
	assign mf_val  = (issue_op == mips_op_pkg::OP_MFHI) ? hi : lo;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			div_state <= mips_wb_pkg::DIV_IDLE;
			md_req    <= 1'b0;
			hi        <= '0;
			lo        <= '0;
			cnt       <= '0;
		end else begin
			if (md_gnt) begin
				md_req <= 1'b0;
			end
			case (div_state)
				mips_wb_pkg::DIV_IDLE: begin
					if (take) begin
						case (issue_op)
							mips_op_pkg::OP_MULT, mips_op_pkg::OP_MULTU: begin
								hi <= prod[2*XLEN-1:XLEN];
								lo <= prod[XLEN-1:0];
							end
							mips_op_pkg::OP_DIV, mips_op_pkg::OP_DIVU: begin
								div_state <= mips_wb_pkg::DIV_RUN;
								cnt       <= CNT_W'(XLEN);
							end
							default: md_req <= 1'b1;	// Move from HI or LO
						endcase
					end
				end
				mips_wb_pkg::DIV_RUN: begin
					cnt <= cnt - 1'b1;
					if (cnt == CNT_W'(1)) begin
						div_state <= mips_wb_pkg::DIV_FIX;
					end
				end
				default: begin
					if (dzero) begin
						lo <= '1;
						hi <= dvd;
					end else begin
						lo <= neg_q ? -quo : quo;
						hi <= neg_r ? -rem : rem;	// Dividend sign
					end
					div_state <= mips_wb_pkg::DIV_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (take && (issue_op == mips_op_pkg::OP_DIV || issue_op == mips_op_pkg::OP_DIVU)) begin
			quo   <= mag_a;
			rem   <= '0;
			dvs   <= mag_b;
			dvd   <= issue_a;
			neg_q <= sgn && (issue_a[XLEN-1] ^ issue_b[XLEN-1]);
			neg_r <= sgn && issue_a[XLEN-1];
			dzero <= (issue_b == '0);
		end else if (div_state == mips_wb_pkg::DIV_RUN) begin
			if (!diff[XLEN]) begin
				rem <= diff[XLEN-1:0];
				quo <= {quo[XLEN-2:0], 1'b1};
			end else begin
				rem <= shifted[XLEN-1:0];	// Restore
				quo <= {quo[XLEN-2:0], 1'b0};
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take && (issue_op == mips_op_pkg::OP_MFHI || issue_op == mips_op_pkg::OP_MFLO)) begin
			md_rd   <= issue_rd;
			md_data <= mf_val;
			md_zero <= (mf_val == '0);
		end
	end

endmodule

/* design/wb_arbiter.sv */
`timescale 1ns/1ps

module wb_arbiter #(
	parameter int XLEN = 32
) (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         alu_req,
	input  logic [mips_wb_pkg::RD_W-1:0] alu_rd,
	input  logic [XLEN-1:0]              alu_data,
	input  logic                         alu_zero,
	input  logic                         md_req,
	input  logic [mips_wb_pkg::RD_W-1:0] md_rd,
	input  logic [XLEN-1:0]              md_data,
	input  logic                         md_zero,
	output logic                         alu_gnt,
	output logic                         md_gnt,
	output logic                         wb_valid,
	output logic [mips_wb_pkg::RD_W-1:0] wb_rd,
	output logic [XLEN-1:0]              wb_data,
	output logic                         wb_zero
);

	mips_wb_pkg::wb_src_e last_src;
	logic                 slot_free;
	logic                 pick_md;

	// No new grant while one is outstanding, so writebacks never abut
	assign slot_free = !alu_gnt && !md_gnt;
	assign pick_md   = md_req && (!alu_req || last_src == mips_wb_pkg::SRC_ALU);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			alu_gnt  <= 1'b0;
			md_gnt   <= 1'b0;
			wb_valid <= 1'b0;
			last_src <= mips_wb_pkg::SRC_MD;	// ALU wins the first tie
		end else begin
			alu_gnt  <= slot_free && alu_req && !pick_md;
			md_gnt   <= slot_free && pick_md;
			wb_valid <= alu_gnt || md_gnt;
			if (slot_free && (alu_req || md_req)) begin
				last_src <= pick_md ? mips_wb_pkg::SRC_MD : mips_wb_pkg::SRC_ALU;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (alu_gnt) begin
			wb_rd   <= alu_rd;
			wb_data <= alu_data;
			wb_zero <= alu_zero;
		end else if (md_gnt) begin
			wb_rd   <= md_rd;
			wb_data <= md_data;
			wb_zero <= md_zero;
		end
	end

endmodule

/* design/exec_stage.sv */
`timescale 1ns/1ps

module exec_stage #(
	parameter int XLEN = mips_op_pkg::XLEN_DEF
) (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         issue_valid,
	input  mips_op_pkg::alu_op_e         issue_op,
	input  logic [XLEN-1:0]              issue_a,
	input  logic [XLEN-1:0]              issue_b,
	input  logic [mips_wb_pkg::RD_W-1:0] issue_rd,
	output logic                         issue_ready,
	output logic                         md_busy,
	output logic                         wb_valid,
	output logic [mips_wb_pkg::RD_W-1:0] wb_rd,
	output logic [XLEN-1:0]              wb_data,
	output logic                         wb_zero
);

	logic                         alu_ready;
	logic                         alu_req;
	logic                         alu_gnt;
	logic [mips_wb_pkg::RD_W-1:0] alu_rd;
	logic [XLEN-1:0]              alu_data;
	logic                         alu_zero;
	logic                         md_ready;
	logic                         md_req;
	logic                         md_gnt;
	logic [mips_wb_pkg::RD_W-1:0] md_rd;
	logic [XLEN-1:0]              md_data;
	logic                         md_zero;

	assign issue_ready = mips_op_pkg::is_muldiv(issue_op) ? md_ready : alu_ready;

	alu_unit #(.XLEN(XLEN)) alu_unit_inst (
		.clk(clk), .rst_n(rst_n),
		.issue_valid(issue_valid), .issue_op(issue_op),
		.issue_a(issue_a), .issue_b(issue_b), .issue_rd(issue_rd),
		.alu_gnt(alu_gnt), .alu_ready(alu_ready), .alu_req(alu_req),
		.alu_rd(alu_rd), .alu_data(alu_data), .alu_zero(alu_zero)
	);

	muldiv_unit #(.XLEN(XLEN)) muldiv_unit_inst (
		.clk(clk), .rst_n(rst_n),
		.issue_valid(issue_valid), .issue_op(issue_op),
		.issue_a(issue_a), .issue_b(issue_b), .issue_rd(issue_rd),
		.md_gnt(md_gnt), .md_ready(md_ready), .md_busy(md_busy), .md_req(md_req),
		.md_rd(md_rd), .md_data(md_data), .md_zero(md_zero)
	);

	wb_arbiter #(.XLEN(XLEN)) wb_arbiter_inst (
		.clk(clk), .rst_n(rst_n),
		.alu_req(alu_req), .alu_rd(alu_rd), .alu_data(alu_data), .alu_zero(alu_zero),
		.md_req(md_req), .md_rd(md_rd), .md_data(md_data), .md_zero(md_zero),
		.alu_gnt(alu_gnt), .md_gnt(md_gnt),
		.wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data), .wb_zero(wb_zero)
	);

endmodule

/* verification/exec_stage_chk.sv */
`timescale 1ns/1ps

module exec_stage_chk #(
	parameter int XLEN = 32
) (
	input logic                         clk,
	input logic                         rst_n,
	input logic                         wb_valid,
	input logic                         alu_gnt,
	input logic                         md_gnt,
	input logic                         md_ready,
	input mips_wb_pkg::div_state_e      div_state,
	input mips_wb_pkg::wb_src_e         last_src,
	input logic                         alu_req,
	input logic [mips_wb_pkg::RD_W-1:0] alu_rd,
	input logic [XLEN-1:0]              alu_data
);

	int err_cnt = 0;	// Read by the testbench

	task automatic note_failure(input string what);
		$error("%s", what);
		err_cnt++;
	endtask

	assert property (@(posedge clk) disable iff (!rst_n) wb_valid |=> !wb_valid)
		else note_failure("wb_valid high two cycles in a row");
	assert property (@(posedge clk) disable iff (!rst_n) !(alu_gnt && md_gnt))
		else note_failure("Both grants high together");
	assert property (@(posedge clk) disable iff (!rst_n)
		(div_state != mips_wb_pkg::DIV_IDLE) |-> !md_ready)
		else note_failure("md_ready high while the divider runs");
	// A tie goes to the unit not granted last time
	assert property (@(posedge clk) disable iff (!rst_n)
		(alu_req && md_req_tie() && last_src == mips_wb_pkg::SRC_MD) |=> alu_gnt)
		else note_failure("Tie not granted to the ALU after a multiply/divide grant");
	assert property (@(posedge clk) disable iff (!rst_n)
		(alu_req && md_req_tie() && last_src == mips_wb_pkg::SRC_ALU) |=> md_gnt)
		else note_failure("Tie not granted to the multiply/divide unit after an ALU grant");
	assert property (@(posedge clk) disable iff (!rst_n)
		(alu_req && !alu_gnt) |=> (alu_req && $stable(alu_data) && $stable(alu_rd)))
		else note_failure("ALU request dropped or changed before its grant");

	// Both units waiting and no grant outstanding
	function automatic logic md_req_tie();
		return md_req && !alu_gnt && !md_gnt;
	endfunction

	logic md_req;

	assign md_req = exec_stage.md_req;

endmodule

bind exec_stage exec_stage_chk #(.XLEN(XLEN)) exec_stage_chk_inst (
	.clk(clk), .rst_n(rst_n), .wb_valid(wb_valid),
	.alu_gnt(alu_gnt), .md_gnt(md_gnt), .md_ready(md_ready),
	.div_state(muldiv_unit_inst.div_state), .last_src(wb_arbiter_inst.last_src),
	.alu_req(alu_req), .alu_rd(alu_rd), .alu_data(alu_data)
);

/* verification/exec_stage_tb.sv */
`timescale 1ns/1ps

module exec_stage_tb;

	localparam int XLEN    = mips_op_pkg::XLEN_DEF;
	localparam int RD_W    = mips_wb_pkg::RD_W;
	localparam int N_CASES = 33;

	logic                 clk;
	logic                 rst_n;
	logic                 issue_valid;
	mips_op_pkg::alu_op_e issue_op;
	logic [XLEN-1:0]      issue_a;
	logic [XLEN-1:0]      issue_b;
	logic [RD_W-1:0]      issue_rd;
	logic                 issue_ready;
	logic                 md_busy;
	logic                 wb_valid;
	logic [RD_W-1:0]      wb_rd;
	logic [XLEN-1:0]      wb_data;
	logic                 wb_zero;
	logic [31:0]          case_mem [0:6*N_CASES-1];	// Six words per case
	logic [XLEN-1:0]      exp_val [0:(1<<RD_W)-1];
	logic                 pending [0:(1<<RD_W)-1];	// One outstanding result per rd
	int                   n_expect;
	int                   n_checked;

	exec_stage #(.XLEN(XLEN)) exec_stage_inst (
		.clk(clk), .rst_n(rst_n), .issue_valid(issue_valid), .issue_op(issue_op),
		.issue_a(issue_a), .issue_b(issue_b), .issue_rd(issue_rd),
		.issue_ready(issue_ready), .md_busy(md_busy), .wb_valid(wb_valid),
		.wb_rd(wb_rd), .wb_data(wb_data), .wb_zero(wb_zero)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;	// 40 ns period
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1, "Simulation stopped on first error");
	endtask

	task automatic check_value(input string name, input logic [XLEN-1:0] got,
		input logic [XLEN-1:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %s got %h expected %h", name, got, exp);
			abort_run("A DUT output did not match its expected value");
		end
	endtask

	// Drive one case and hold it until the DUT takes it
	task automatic issue_case(input int i, input logic after_div);
		mips_op_pkg::alu_op_e op;
		logic [RD_W-1:0]      rd;
		logic                 has_wb;
		int                   stall;
		op     = mips_op_pkg::alu_op_e'(case_mem[6*i][4:0]);
		rd     = case_mem[6*i+3][RD_W-1:0];
		has_wb = case_mem[6*i+5][0];
		stall  = 0;
		while (has_wb && pending[rd]) begin	// Earlier result to this rd still in flight
			issue_valid = 1'b0;
			@(posedge clk);
			#2;
		end
		issue_valid = 1'b1;
		issue_op    = op;
		issue_a     = case_mem[6*i+1];
		issue_b     = case_mem[6*i+2];
		issue_rd    = rd;
		if (has_wb) begin
			exp_val[rd] = case_mem[6*i+4];
			pending[rd] = 1'b1;
			n_expect++;
		end
		@(negedge clk);
		while (!issue_ready) begin
			if (after_div && mips_op_pkg::is_muldiv(op)) begin
				check_value("md_busy", md_busy, 1);	// Divider still running
			end
			stall++;
			@(negedge clk);
		end
		if (mips_op_pkg::is_muldiv(op)) begin
			check_value("md_busy", md_busy, 0);
		end
		if (after_div && mips_op_pkg::is_muldiv(op)) begin
			check_value("divide_stall", stall != 0, 1);	// Must wait for md_busy to fall
		end
		@(posedge clk);
		#2;
	endtask

	// Scoreboard on every writeback pulse
	always @(negedge clk) begin
		if (rst_n && wb_valid) begin
			if (!pending[wb_rd]) begin
				abort_run($sformatf("Writeback to register %0d with no result pending", wb_rd));
			end
			check_value("wb_data", wb_data, exp_val[wb_rd]);
			check_value("wb_zero", wb_zero, exp_val[wb_rd] == '0);
			pending[wb_rd] = 1'b0;
			n_checked++;
		end
	end

	always @(negedge clk) begin
		if (exec_stage_inst.exec_stage_chk_inst.err_cnt != 0) begin
			abort_run("An assertion in the bound checker failed");
		end
	end

	initial begin
		repeat (N_CASES * 60) @(posedge clk);
		abort_run("Timeout while waiting for the DUT to finish the cases");
	end

	initial begin
		mips_op_pkg::alu_op_e prev_op;
		rst_n       = 1'b0;
		issue_valid = 1'b0;
		issue_op    = mips_op_pkg::OP_AND;
		issue_a     = '0;
		issue_b     = '0;
		issue_rd    = '0;
		n_expect    = 0;
		n_checked   = 0;
		prev_op     = mips_op_pkg::OP_AND;
		for (int r = 0; r < (1 << RD_W); r++) begin
			pending[r] = 1'b0;
		end
		$readmemh("verification/exec_cases.mem", case_mem);
		repeat (3) @(posedge clk);
		#2;
		rst_n = 1'b1;
		for (int i = 0; i < N_CASES; i++) begin
			issue_case(i, prev_op inside {mips_op_pkg::OP_DIV, mips_op_pkg::OP_DIVU});
			prev_op = mips_op_pkg::alu_op_e'(case_mem[6*i][4:0]);
		end
		issue_valid = 1'b0;
		wait (n_checked == n_expect);
		repeat (4) @(posedge clk);	// Catch a repeated writeback
		if (exec_stage_inst.exec_stage_chk_inst.err_cnt == 0) begin
			$display("Test completed successfully");
			$finish;
		end else begin
			abort_run("An assertion in the bound checker failed during the run");
		end
	end

endmodule

/* verification/exec_cases.mem */
// Columns op a b rd expected has_wb in hex
// MULT and DIV forms have has_wb 0 since they only load HI and LO
00 f0f01234 0ff0ff00 01 00f01200 1
03 ffffffff 00000002 02 00000001 1
04 00000005 00000005 03 00000000 1
05 00000001 ffffffff 04 00000001 1
06 00000001 ffffffff 05 00000000 1
08 fffffffd 00000007 00 00000000 0
11 00000000 00000000 06 ffffffff 1
09 00000003 00000024 07 00000030 1
12 00000000 00000000 08 ffffffeb 1
0b 80000000 00000004 09 f8000000 1
07 fffffffd 00000007 00 00000000 0
11 00000000 00000000 0a 00000006 1
17 00000000 00001234 0b 12340000 1
0f fffffff9 00000002 00 00000000 0
12 00000000 00000000 0c fffffffd 1
13 fffffffe 00000000 0d 00000000 1
11 00000000 00000000 0e ffffffff 1
0f 00000007 fffffffe 00 00000000 0
14 00000000 00000000 0f 00000001 1
12 00000000 00000000 10 fffffffd 1
11 00000000 00000000 11 00000001 1
0f fffffff9 fffffffe 00 00000000 0
12 00000000 00000000 12 00000003 1
15 00000000 00000000 13 00000000 1
11 00000000 00000000 14 ffffffff 1
0f 00000007 00000002 00 00000000 0
12 00000000 00000000 15 00000003 1
10 ffffffff 00000010 00 00000000 0
12 00000000 00000000 16 0fffffff 1
16 00000000 00000000 17 00000001 1
0f fffffff9 00000000 00 00000000 0
11 00000000 00000000 01 fffffff9 1
12 00000000 00000000 02 ffffffff 1

/* list.f */
design/mips_op_pkg.sv
design/mips_wb_pkg.sv
design/alu_unit.sv
design/muldiv_unit.sv
design/wb_arbiter.sv
design/exec_stage.sv
verification/exec_stage_chk.sv
verification/exec_stage_tb.sv
